/* common/rv_commit_macros.svh */
`ifndef RV_COMMIT_MACROS_SVH
`define RV_COMMIT_MACROS_SVH

// data and address width
`define RV_XLEN 32
// trap vector base after reset, direct mode
`define RV_MTVEC_RESET 32'h0000_0100

// mstatus field positions
`define RV_MSTATUS_MIE 3
`define RV_MSTATUS_MPIE 7
`define RV_MSTATUS_MPP 12:11
// mie and mip share these bit positions
`define RV_MI_MS 3
`define RV_MI_MT 7
`define RV_MI_ME 11

`endif

/* common/rv_commit_pkg.sv */
package rv_commit_pkg;

	// error code carried by an instruction from the front end
	typedef enum logic [2:0] {
		ERR_NONE           = 3'b000, // clean
		ERR_ILLEGAL        = 3'b001, // illegal encoding
		ERR_PC_MISALIGN    = 3'b010, // fetch address misaligned
		ERR_IBUS_FAULT     = 3'b011, // instruction bus error
		ERR_LOAD_MISALIGN  = 3'b110, // load address misaligned
		ERR_STORE_MISALIGN = 3'b111  // store address misaligned
	} inst_err_e;

	// mcause code field, interrupt flag travels separately
	typedef enum logic [7:0] {
		CAUSE_INST_MISALIGN  = 8'd0,
		CAUSE_INST_FAULT     = 8'd1,
		CAUSE_ILLEGAL        = 8'd2,
		CAUSE_M_SW           = 8'd3, // machine software interrupt
		CAUSE_LOAD_MISALIGN  = 8'd4,
		CAUSE_LOAD_FAULT     = 8'd5,
		CAUSE_STORE_MISALIGN = 8'd6,
		CAUSE_STORE_FAULT    = 8'd7,
		CAUSE_M_ECALL        = 8'd11
	} trap_cause_e;

	// timer and external interrupts reuse the exception codes 7 and 11
	localparam trap_cause_e CAUSE_M_TMR = CAUSE_STORE_FAULT;
	localparam trap_cause_e CAUSE_M_EXT = CAUSE_M_ECALL;

	// bus error kind reported by the LSU
	typedef enum logic {
		LSU_LOAD_FAULT  = 1'b0,
		LSU_STORE_FAULT = 1'b1
	} lsu_err_e;

	// register select of the CSR access port
	typedef enum logic [2:0] {
		CSR_MSTATUS = 3'd0,
		CSR_MIE     = 3'd1,
		CSR_MTVEC   = 3'd2,
		CSR_MEPC    = 3'd3,
		CSR_MCAUSE  = 3'd4,
		CSR_MTVAL   = 3'd5,
		CSR_MIP     = 3'd6
	} csr_sel_e;

	function automatic logic is_sync_fault(inst_err_e code);
		return code[0] | code[1]; // any of the low two bits flags a fault
	endfunction

endpackage

/* commit/rv_commit.sv */
`include "rv_commit_macros.svh"

module rv_commit import rv_commit_pkg::*;
(
	input  logic                clk,
	input  logic                resetn,

	input  logic                mstatus_mie_v, // global interrupt enable
	input  logic                mie_msie_v,
	input  logic                mie_mtie_v,
	input  logic                mie_meie_v,

	input  logic [`RV_XLEN-1:0] s_pst_inst, // raw instruction, for illegal only
	input  inst_err_e           s_pst_err_code,
	input  logic [`RV_XLEN-1:0] s_pst_pc_of_inst,
	input  logic                s_pst_is_b_inst,
	input  logic                s_pst_is_ecall_inst,
	input  logic                s_pst_is_mret_inst,
	input  logic [`RV_XLEN-1:0] s_pst_brc_pc_upd, // corrected pc of a branch
	input  logic                s_pst_prdt_jump,
	input  logic                s_pst_is_long_inst, // load/store, mul/div
	input  logic                s_pst_valid,
	output logic                s_pst_ready,

	input  logic [`RV_XLEN-1:0] s_lsu_expt_ls_addr,
	input  lsu_err_e            s_lsu_expt_err,
	input  logic                s_lsu_expt_valid,
	output logic                s_lsu_expt_ready,

	output logic                m_pst_inst_cmt,
	output logic                m_pst_need_imdt_wbk,
	output logic                m_pst_valid,
	input  logic                m_pst_ready,

	input  logic [`RV_XLEN-1:0] ls_addr, // agu address of a load/store
	input  logic                cfr_jump, // resolved branch direction

	input  logic                sw_itr_req, // levels, held until cleared at source
	input  logic                tmr_itr_req,
	input  logic                ext_itr_req,

	output logic                itr_expt_enter,
	output logic                itr_expt_is_intr,
	output trap_cause_e         itr_expt_cause,
	input  logic [`RV_XLEN-1:0] itr_expt_vec_baseaddr,
	output logic [`RV_XLEN-1:0] itr_expt_ret_addr,
	output logic [`RV_XLEN-1:0] itr_expt_val,

	output logic                itr_expt_ret,
	input  logic [`RV_XLEN-1:0] mepc_ret_addr,

	output logic                flush_req,
	input  logic                flush_ack,
	output logic [`RV_XLEN-1:0] flush_addr
);

	logic inst_fault; // instruction carries a sync fault
	logic pst_hs; // instruction accepted this cycle
	logic ecall_ok; // clean ecall
	logic mret_ok; // clean mret
	logic brc_prdt_failed;
	logic sw_itr_req_vld;
	logic tmr_itr_req_vld;
	logic ext_itr_req_vld;
	logic intr_req_vld;
	logic lsu_expt_req_vld;
	logic sync_expt_req_vld;
	logic lsu_expt_req_granted;
	logic sync_expt_req_granted;
	logic trap_processing; // inside a handler, no nesting
	logic flush_pending; // waiting for flush_ack

	assign inst_fault = is_sync_fault(s_pst_err_code);
	assign pst_hs     = s_pst_valid & s_pst_ready;
	assign ecall_ok   = ~inst_fault & s_pst_is_ecall_inst;
	assign mret_ok    = ~inst_fault & s_pst_is_mret_inst;

	// prediction differs from the resolved direction
	assign brc_prdt_failed = s_pst_valid & ~inst_fault & s_pst_is_b_inst &
		(s_pst_prdt_jump ^ cfr_jump);

	// masked interrupt requests, MIE is cleared on trap entry
	assign sw_itr_req_vld  = mstatus_mie_v & mie_msie_v & sw_itr_req;
	assign tmr_itr_req_vld = mstatus_mie_v & mie_mtie_v & tmr_itr_req;
	assign ext_itr_req_vld = mstatus_mie_v & mie_meie_v & ext_itr_req;
	assign intr_req_vld    = sw_itr_req_vld | tmr_itr_req_vld | ext_itr_req_vld;

	// sync and lsu faults dropped while a handler runs
	assign lsu_expt_req_vld  = ~trap_processing & s_lsu_expt_valid;
	assign sync_expt_req_vld = ~trap_processing & s_pst_valid & inst_fault;

	// mispredict > ext > sw > tmr > lsu > sync
	assign lsu_expt_req_granted  = ~brc_prdt_failed & ~intr_req_vld & lsu_expt_req_vld;
	assign sync_expt_req_granted = ~brc_prdt_failed & ~intr_req_vld & ~lsu_expt_req_vld &
		sync_expt_req_vld;

	// an ecall or faulted instruction may lose to an interrupt here
	assign itr_expt_enter = pst_hs & ~brc_prdt_failed &
		(intr_req_vld | lsu_expt_req_vld | sync_expt_req_vld | ecall_ok);
	assign itr_expt_is_intr = intr_req_vld;
	assign itr_expt_ret     = pst_hs & mret_ok;

	always_comb
	begin
		itr_expt_cause = CAUSE_INST_MISALIGN; // don't care without enter
		if (ext_itr_req_vld)
			itr_expt_cause = CAUSE_M_EXT;
		else if (sw_itr_req_vld)
			itr_expt_cause = CAUSE_M_SW;
		else if (tmr_itr_req_vld)
			itr_expt_cause = CAUSE_M_TMR;
		else if (lsu_expt_req_vld)
		begin
			if (s_lsu_expt_err == LSU_STORE_FAULT)
				itr_expt_cause = CAUSE_STORE_FAULT;
			else
				itr_expt_cause = CAUSE_LOAD_FAULT;
		end
		else if (sync_expt_req_vld)
		begin
			case (s_pst_err_code)
				ERR_ILLEGAL:        itr_expt_cause = CAUSE_ILLEGAL;
				ERR_PC_MISALIGN:    itr_expt_cause = CAUSE_INST_MISALIGN;
				ERR_IBUS_FAULT:     itr_expt_cause = CAUSE_INST_FAULT;
				ERR_LOAD_MISALIGN:  itr_expt_cause = CAUSE_LOAD_MISALIGN;
				ERR_STORE_MISALIGN: itr_expt_cause = CAUSE_STORE_MISALIGN;
				default:            itr_expt_cause = CAUSE_INST_MISALIGN;
			endcase
		end
		else if (ecall_ok)
			itr_expt_cause = CAUSE_M_ECALL;
	end

	// faulted instruction is refetched, everything else resumes at pc+4
	assign itr_expt_ret_addr = s_pst_pc_of_inst +
		{{(`RV_XLEN-3){1'b0}}, ~sync_expt_req_vld, 2'b00};

	always_comb
	begin
		itr_expt_val = '0;
		if (lsu_expt_req_granted)
			itr_expt_val = s_lsu_expt_ls_addr; // bus error address from lsu
		else if (sync_expt_req_granted)
		begin
			case (s_pst_err_code)
				ERR_LOAD_MISALIGN, ERR_STORE_MISALIGN: itr_expt_val = ls_addr;
				ERR_PC_MISALIGN, ERR_IBUS_FAULT:       itr_expt_val = s_pst_pc_of_inst;
				ERR_ILLEGAL:                           itr_expt_val = s_pst_inst;
				default:                               itr_expt_val = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			trap_processing <= 1'b0;
		else if (itr_expt_enter | itr_expt_ret)
			trap_processing <= itr_expt_enter; // entry wins over return
	end

	assign flush_req = pst_hs & (brc_prdt_failed | ecall_ok | mret_ok | intr_req_vld |
		lsu_expt_req_vld | sync_expt_req_vld);
	assign flush_addr = brc_prdt_failed ? s_pst_brc_pc_upd :
		mret_ok ? mepc_ret_addr : itr_expt_vec_baseaddr;

	// set on the request edge unless acked at once, cleared after the ack
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			flush_pending <= 1'b0;
		else
			flush_pending <= (flush_pending | flush_req) & ~flush_ack;
	end

	assign s_pst_ready      = ~flush_pending & m_pst_ready;
	assign m_pst_valid      = ~flush_pending & s_pst_valid;
	// lsu fault only taken together with an instruction handshake
	assign s_lsu_expt_ready = ~flush_pending & m_pst_ready & s_pst_valid & lsu_expt_req_granted;

	assign m_pst_inst_cmt      = ~sync_expt_req_vld; // cancelled only on a taken sync fault
	assign m_pst_need_imdt_wbk = m_pst_inst_cmt & ~s_pst_is_long_inst;

endmodule

/* src/rv_trap_csr.sv */
`include "rv_commit_macros.svh"

module rv_trap_csr import rv_commit_pkg::*;
(
	input  logic                clk,
	input  logic                resetn,

	input  logic                itr_expt_enter,
	input  logic                itr_expt_is_intr,
	input  trap_cause_e         itr_expt_cause,
	input  logic [`RV_XLEN-1:0] itr_expt_ret_addr,
	input  logic [`RV_XLEN-1:0] itr_expt_val,

	input  logic                itr_expt_ret,

	input  logic                sw_itr_req, // raw levels seen in mip
	input  logic                tmr_itr_req,
	input  logic                ext_itr_req,

	input  logic                csr_wen,
	input  csr_sel_e            csr_sel,
	input  logic [`RV_XLEN-1:0] csr_wdata,
	output logic [`RV_XLEN-1:0] csr_rdata,

	output logic                mstatus_mie_v,
	output logic                mie_msie_v,
	output logic                mie_mtie_v,
	output logic                mie_meie_v,

	output logic [`RV_XLEN-1:0] itr_expt_vec_baseaddr,
	output logic [`RV_XLEN-1:0] mepc_ret_addr
);

	logic                mstatus_mie;
	logic                mstatus_mpie;
	logic                mie_msie;
	logic                mie_mtie;
	logic                mie_meie;
	logic [`RV_XLEN-1:0] mtvec; // direct mode, low bits held at 0
	logic [`RV_XLEN-1:0] mepc;
	logic [`RV_XLEN-1:0] mcause;
	logic [`RV_XLEN-1:0] mtval;

	// MIE/MPIE stack, trap events take precedence over a write
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end
		else if (itr_expt_enter)
		begin
			mstatus_mpie <= mstatus_mie; // save and mask
			mstatus_mie  <= 1'b0;
		end
		else if (itr_expt_ret)
		begin
			mstatus_mie  <= mstatus_mpie; // restore
			mstatus_mpie <= 1'b1;
		end
		else if (csr_wen && csr_sel == CSR_MSTATUS)
		begin
			mstatus_mie  <= csr_wdata[`RV_MSTATUS_MIE];
			mstatus_mpie <= csr_wdata[`RV_MSTATUS_MPIE];
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mie_msie <= 1'b0;
			mie_mtie <= 1'b0;
			mie_meie <= 1'b0;
			mtvec    <= `RV_MTVEC_RESET;
		end
		else if (csr_wen)
		begin
			if (csr_sel == CSR_MIE)
			begin
				mie_msie <= csr_wdata[`RV_MI_MS];
				mie_mtie <= csr_wdata[`RV_MI_MT];
				mie_meie <= csr_wdata[`RV_MI_ME];
			end
			if (csr_sel == CSR_MTVEC)
				mtvec <= {csr_wdata[`RV_XLEN-1:2], 2'b00}; // mode field forced to direct
		end
	end

	// trap record, loaded on entry or by software
	always_ff @(posedge clk)
	begin
		if (itr_expt_enter)
		begin
			mepc   <= {itr_expt_ret_addr[`RV_XLEN-1:2], 2'b00};
			mcause <= {itr_expt_is_intr, {(`RV_XLEN-9){1'b0}}, itr_expt_cause};
			mtval  <= itr_expt_val;
		end
		else if (csr_wen)
		begin
			if (csr_sel == CSR_MEPC)
				mepc <= {csr_wdata[`RV_XLEN-1:2], 2'b00};
			if (csr_sel == CSR_MCAUSE)
				mcause <= csr_wdata;
			if (csr_sel == CSR_MTVAL)
				mtval <= csr_wdata;
		end
	end

	always_comb
	begin
		csr_rdata = '0;
		case (csr_sel)
			CSR_MSTATUS:
			begin
				csr_rdata[`RV_MSTATUS_MIE]  = mstatus_mie;
				csr_rdata[`RV_MSTATUS_MPIE] = mstatus_mpie;
				csr_rdata[`RV_MSTATUS_MPP]  = 2'b11; // machine mode only
			end
			CSR_MIE:
			begin
				csr_rdata[`RV_MI_MS] = mie_msie;
				csr_rdata[`RV_MI_MT] = mie_mtie;
				csr_rdata[`RV_MI_ME] = mie_meie;
			end
			CSR_MIP:
			begin
				csr_rdata[`RV_MI_MS] = sw_itr_req; // read-only pending view
				csr_rdata[`RV_MI_MT] = tmr_itr_req;
				csr_rdata[`RV_MI_ME] = ext_itr_req;
			end
			CSR_MTVEC:  csr_rdata = mtvec;
			CSR_MEPC:   csr_rdata = mepc;
			CSR_MCAUSE: csr_rdata = mcause;
			CSR_MTVAL:  csr_rdata = mtval;
			default:    csr_rdata = '0;
		endcase
	end

	assign mstatus_mie_v         = mstatus_mie;
	assign mie_msie_v            = mie_msie;
	assign mie_mtie_v            = mie_mtie;
	assign mie_meie_v            = mie_meie;
	assign itr_expt_vec_baseaddr = mtvec;
	assign mepc_ret_addr         = mepc;

endmodule

/* src/rv_commit_top.sv */
`include "rv_commit_macros.svh"

module rv_commit_top import rv_commit_pkg::*;
(
	input  logic                clk,
	input  logic                resetn,

	input  logic [`RV_XLEN-1:0] s_pst_inst,
	input  inst_err_e           s_pst_err_code,
	input  logic [`RV_XLEN-1:0] s_pst_pc_of_inst,
	input  logic                s_pst_is_b_inst,
	input  logic                s_pst_is_ecall_inst,
	input  logic                s_pst_is_mret_inst,
	input  logic [`RV_XLEN-1:0] s_pst_brc_pc_upd,
	input  logic                s_pst_prdt_jump,
	input  logic                s_pst_is_long_inst,
	input  logic                s_pst_valid,
	output logic                s_pst_ready,

	input  logic [`RV_XLEN-1:0] s_lsu_expt_ls_addr,
	input  lsu_err_e            s_lsu_expt_err,
	input  logic                s_lsu_expt_valid,
	output logic                s_lsu_expt_ready,

	output logic                m_pst_inst_cmt,
	output logic                m_pst_need_imdt_wbk,
	output logic                m_pst_valid,
	input  logic                m_pst_ready,

	input  logic [`RV_XLEN-1:0] ls_addr,
	input  logic                cfr_jump,

	input  logic                sw_itr_req,
	input  logic                tmr_itr_req,
	input  logic                ext_itr_req,

	output logic                itr_expt_enter, // trap entry strobe
	output logic                itr_expt_is_intr,
	output trap_cause_e         itr_expt_cause,
	output logic [`RV_XLEN-1:0] itr_expt_ret_addr,
	output logic [`RV_XLEN-1:0] itr_expt_val,
	output logic                itr_expt_ret, // mret strobe

	output logic                flush_req,
	input  logic                flush_ack,
	output logic [`RV_XLEN-1:0] flush_addr,

	input  logic                csr_wen,
	input  csr_sel_e            csr_sel,
	input  logic [`RV_XLEN-1:0] csr_wdata,
	output logic [`RV_XLEN-1:0] csr_rdata
);

	// enables and addresses fed back from the csr block
	logic                mstatus_mie_v;
	logic                mie_msie_v;
	logic                mie_mtie_v;
	logic                mie_meie_v;
	logic [`RV_XLEN-1:0] itr_expt_vec_baseaddr;
	logic [`RV_XLEN-1:0] mepc_ret_addr;

	rv_commit u_commit (.*); // all names match one to one

	rv_trap_csr u_trap_csr (.*);

endmodule

/* bench/tb_rv_commit.sv */
`include "rv_commit_macros.svh"

module tb_rv_commit import rv_commit_pkg::*; ();

	// flag columns {b, prdt, cfr, long, ecall, mret, lsu_v, lsu_store}
	localparam logic [7:0] F_B = 8'h80, F_PRDT = 8'h40, F_CFR = 8'h20, F_LONG = 8'h10;
	localparam logic [7:0] F_ECALL = 8'h08, F_MRET = 8'h04, F_LSU = 8'h02, F_ST = 8'h01;
	// irq columns {ext, sw, tmr}
	localparam logic [2:0] I_EXT = 3'h4, I_SW = 3'h2, I_TMR = 3'h1;
	// result columns {cmt, wbk, flush, enter, intr, ret, mie after}
	localparam logic [6:0] R_CMT = 7'h40, R_WBK = 7'h20, R_FL = 7'h10, R_EN = 7'h08;
	localparam logic [6:0] R_INTR = 7'h04, R_RET = 7'h02, R_MIE = 7'h01;
	localparam logic [`RV_XLEN-1:0] MV = `RV_MTVEC_RESET;

	typedef struct {
		logic                wr; // csr write step
		csr_sel_e            sel;
		logic [`RV_XLEN-1:0] wdata;
		inst_err_e           err;
		logic [`RV_XLEN-1:0] inst, pc, addr; // addr feeds brc, ls and lsu address
		logic [7:0]          flg;
		logic [2:0]          irq;
		logic [6:0]          res;
		logic [`RV_XLEN-1:0] faddr, mepc, mtval;
		trap_cause_e         cause;
	} step_t;

	logic clk, resetn;
	logic [`RV_XLEN-1:0] s_pst_inst, s_pst_pc_of_inst, s_pst_brc_pc_upd, s_lsu_expt_ls_addr;
	inst_err_e s_pst_err_code;
	logic s_pst_is_b_inst, s_pst_is_ecall_inst, s_pst_is_mret_inst, s_pst_prdt_jump;
	logic s_pst_is_long_inst, s_pst_valid, s_pst_ready;
	lsu_err_e s_lsu_expt_err;
	logic s_lsu_expt_valid, s_lsu_expt_ready;
	logic m_pst_inst_cmt, m_pst_need_imdt_wbk, m_pst_valid, m_pst_ready;
	logic [`RV_XLEN-1:0] ls_addr, itr_expt_ret_addr, itr_expt_val, flush_addr;
	logic cfr_jump, sw_itr_req, tmr_itr_req, ext_itr_req;
	logic itr_expt_enter, itr_expt_is_intr, itr_expt_ret, flush_req, flush_ack;
	trap_cause_e itr_expt_cause;
	logic csr_wen;
	csr_sel_e csr_sel;
	logic [`RV_XLEN-1:0] csr_wdata, csr_rdata;

	step_t tbl[$];
	logic [31:0] lfsr = 32'h70c07961;
	int cycles = 0;
	int limit = 0; // armed once the table is loaded

	rv_commit_top DUT (
		.clk, .resetn, .s_pst_inst, .s_pst_err_code, .s_pst_pc_of_inst, .s_pst_is_b_inst,
		.s_pst_is_ecall_inst, .s_pst_is_mret_inst, .s_pst_brc_pc_upd, .s_pst_prdt_jump,
		.s_pst_is_long_inst, .s_pst_valid, .s_pst_ready, .s_lsu_expt_ls_addr, .s_lsu_expt_err,
		.s_lsu_expt_valid, .s_lsu_expt_ready, .m_pst_inst_cmt, .m_pst_need_imdt_wbk,
		.m_pst_valid, .m_pst_ready, .ls_addr, .cfr_jump, .sw_itr_req, .tmr_itr_req,
		.ext_itr_req, .itr_expt_enter, .itr_expt_is_intr, .itr_expt_cause, .itr_expt_ret_addr,
		.itr_expt_val, .itr_expt_ret, .flush_req, .flush_ack, .flush_addr, .csr_wen, .csr_sel,
		.csr_wdata, .csr_rdata
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (limit > 0 && cycles >= limit)
		begin
			$display("=== FAIL ===");
			$fatal(1, "timeout, the run did not finish within %0d cycles", limit);
		end
	end

	// galois lfsr, one step per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp)
		begin
			$display("FAILED t=%0t %s exp=%b got=%b", $time, name, exp, got);
			$display("=== FAIL ===");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic check_word(input string name, input logic [`RV_XLEN-1:0] exp,
		input logic [`RV_XLEN-1:0] got);
		if (got !== exp)
		begin
			$display("FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
			$display("=== FAIL ===");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_cause(input string name, input trap_cause_e exp, input trap_cause_e got);
		if (got !== exp)
		begin
			$display("FAILED t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
			$display("=== FAIL ===");
			$fatal(1, "cause mismatch");
		end
	endtask

	task automatic put_csr(input csr_sel_e sel, input logic [`RV_XLEN-1:0] data);
		step_t s;
		s = '{sel: CSR_MSTATUS, err: ERR_NONE, cause: CAUSE_INST_MISALIGN, default: '0};
		s.wr = 1'b1;
		s.sel = sel;
		s.wdata = data;
		tbl.push_back(s);
	endtask

	task automatic put_inst(input inst_err_e err, input logic [`RV_XLEN-1:0] inst, pc,
		input logic [7:0] flg, input logic [2:0] irq, input logic [`RV_XLEN-1:0] addr,
		input logic [6:0] res, input logic [`RV_XLEN-1:0] faddr, input trap_cause_e cause,
		input logic [`RV_XLEN-1:0] mepc, mtval);
		step_t s;
		s = '{sel: CSR_MSTATUS, err: ERR_NONE, cause: CAUSE_INST_MISALIGN, default: '0};
		s.err = err;
		s.inst = inst;
		s.pc = pc;
		s.flg = flg;
		s.irq = irq;
		s.addr = addr;
		s.res = res;
		s.faddr = faddr;
		s.cause = cause;
		s.mepc = mepc;
		s.mtval = mtval;
		tbl.push_back(s);
	endtask

	// mret back to the saved pc, MIE comes back from MPIE
	task automatic put_mret(input logic [`RV_XLEN-1:0] pc, target);
		put_inst(ERR_NONE, '0, pc, F_MRET, 3'h0, '0, R_CMT | R_WBK | R_FL | R_RET | R_MIE,
			target, CAUSE_INST_MISALIGN, '0, '0);
	endtask

	task automatic load_table();
		// branch confirm
		put_inst(ERR_NONE, '0, 32'h1000, F_B | F_PRDT, 3'h0, 32'h2000, R_CMT | R_WBK | R_FL,
			32'h2000, CAUSE_INST_MISALIGN, '0, '0);
		put_inst(ERR_NONE, '0, 32'h1004, F_B | F_PRDT | F_CFR, 3'h0, '0, R_CMT | R_WBK, '0,
			CAUSE_INST_MISALIGN, '0, '0);
		put_inst(ERR_NONE, '0, 32'h1008, F_LONG, 3'h0, '0, R_CMT, '0, CAUSE_INST_MISALIGN, '0, '0);
		// interrupts masked by MIE after reset
		put_inst(ERR_NONE, '0, 32'h100c, 8'h0, 3'h7, '0, R_CMT | R_WBK, '0,
			CAUSE_INST_MISALIGN, '0, '0);
		put_csr(CSR_MIE, 32'h88); // sw and tmr only
		put_csr(CSR_MSTATUS, 32'h8);
		put_inst(ERR_NONE, '0, 32'h1100, 8'h0, I_EXT | I_SW | I_TMR, '0,
			R_CMT | R_WBK | R_FL | R_EN | R_INTR,
			MV, CAUSE_M_SW, 32'h1104, '0); // ext masked by mie, sw beats tmr
		put_mret(32'h1200, 32'h1104);
		put_csr(CSR_MIE, 32'h888);
		put_inst(ERR_NONE, '0, 32'h1300, 8'h0, I_EXT | I_TMR, '0,
			R_CMT | R_WBK | R_FL | R_EN | R_INTR, MV, CAUSE_M_EXT, 32'h1304, '0);
		put_mret(32'h1310, 32'h1304);
		put_inst(ERR_NONE, '0, 32'h1400, F_B | F_PRDT, I_TMR, 32'h1500,
			R_CMT | R_WBK | R_FL | R_MIE, 32'h1500, CAUSE_INST_MISALIGN, '0, '0);
		put_inst(ERR_NONE, '0, 32'h1500, 8'h0, I_TMR, '0, R_CMT | R_WBK | R_FL | R_EN | R_INTR,
			MV, CAUSE_M_TMR, 32'h1504, '0);
		put_mret(32'h1600, 32'h1504);
		// synchronous faults, the second one lands inside the handler
		put_inst(ERR_ILLEGAL, 32'hdeadbeef, 32'h2000, 8'h0, 3'h0, '0, R_FL | R_EN, MV,
			CAUSE_ILLEGAL, 32'h2000, 32'hdeadbeef);
		put_inst(ERR_ILLEGAL, 32'h12345678, 32'h2010, 8'h0, 3'h0, '0, R_CMT | R_WBK, '0,
			CAUSE_INST_MISALIGN, '0, '0);
		put_mret(32'h2020, 32'h2000);
		put_inst(ERR_PC_MISALIGN, '0, 32'h2204, 8'h0, 3'h0, '0, R_FL | R_EN, MV,
			CAUSE_INST_MISALIGN, 32'h2204, 32'h2204);
		put_mret(32'h2210, 32'h2204);
		put_inst(ERR_IBUS_FAULT, '0, 32'h2300, 8'h0, 3'h0, '0, R_FL | R_EN, MV,
			CAUSE_INST_FAULT, 32'h2300, 32'h2300);
		put_mret(32'h2310, 32'h2300);
		put_inst(ERR_LOAD_MISALIGN, '0, 32'h2400, F_LONG, 3'h0, 32'h3001, R_FL | R_EN, MV,
			CAUSE_LOAD_MISALIGN, 32'h2400, 32'h3001);
		put_mret(32'h2410, 32'h2400);
		put_inst(ERR_STORE_MISALIGN, '0, 32'h2500, F_LONG, 3'h0, 32'h3003, R_FL | R_EN, MV,
			CAUSE_STORE_MISALIGN, 32'h2500, 32'h3003);
		put_mret(32'h2510, 32'h2500);
		// lsu bus errors and ecall
		put_inst(ERR_NONE, '0, 32'h2600, F_LONG | F_LSU, 3'h0, 32'h4000, R_CMT | R_FL | R_EN,
			MV, CAUSE_LOAD_FAULT, 32'h2604, 32'h4000);
		put_mret(32'h2610, 32'h2604);
		put_inst(ERR_NONE, '0, 32'h2700, F_LONG | F_LSU | F_ST, 3'h0, 32'h4008,
			R_CMT | R_FL | R_EN, MV, CAUSE_STORE_FAULT, 32'h2704, 32'h4008);
		put_mret(32'h2710, 32'h2704);
		put_inst(ERR_NONE, '0, 32'h2800, F_ECALL, 3'h0, '0, R_CMT | R_WBK | R_FL | R_EN, MV,
			CAUSE_M_ECALL, 32'h2804, '0);
		put_mret(32'h2810, 32'h2804);
	endtask

	task automatic clear_inputs();
		s_pst_valid = 1'b0;
		s_pst_inst = '0;
		s_pst_err_code = ERR_NONE;
		s_pst_pc_of_inst = '0;
		{s_pst_is_b_inst, s_pst_prdt_jump, cfr_jump, s_pst_is_long_inst} = 4'h0;
		{s_pst_is_ecall_inst, s_pst_is_mret_inst, s_lsu_expt_valid} = 3'h0;
		s_lsu_expt_err = LSU_LOAD_FAULT;
		{s_pst_brc_pc_upd, ls_addr, s_lsu_expt_ls_addr} = '0;
		{ext_itr_req, sw_itr_req, tmr_itr_req} = 3'h0;
		flush_ack = 1'b0;
	endtask

	task automatic run_step(input int idx);
		step_t s;
		logic [1:0] delay;
		logic [`RV_XLEN-1:0] mcause_exp;
		s = tbl[idx];
		@(posedge clk);
		#10;
		if (s.wr)
		begin
			csr_wen = 1'b1;
			csr_sel = s.sel;
			csr_wdata = s.wdata;
			@(posedge clk);
			#10;
			csr_wen = 1'b0;
		end
		else
		begin
			s_pst_inst = s.inst;
			s_pst_err_code = s.err;
			s_pst_pc_of_inst = s.pc;
			{s_pst_is_b_inst, s_pst_prdt_jump, cfr_jump, s_pst_is_long_inst} = s.flg[7:4];
			{s_pst_is_ecall_inst, s_pst_is_mret_inst, s_lsu_expt_valid} = s.flg[3:1];
			s_lsu_expt_err = s.flg[0] ? LSU_STORE_FAULT : LSU_LOAD_FAULT;
			{s_pst_brc_pc_upd, ls_addr, s_lsu_expt_ls_addr} = {3{s.addr}};
			{ext_itr_req, sw_itr_req, tmr_itr_req} = s.irq;
			s_pst_valid = 1'b1;
			delay[1] = lfsr_bit(); // ack latency 0..3
			delay[0] = lfsr_bit();
			flush_ack = s.res[4] && delay == 2'd0;
			#5;
			check_bit("s_pst_ready", 1'b1, s_pst_ready);
			check_bit("m_pst_valid", 1'b1, m_pst_valid);
			check_bit("m_pst_inst_cmt", s.res[6], m_pst_inst_cmt);
			check_bit("m_pst_need_imdt_wbk", s.res[5], m_pst_need_imdt_wbk);
			check_bit("flush_req", s.res[4], flush_req);
			check_bit("itr_expt_enter", s.res[3], itr_expt_enter);
			check_bit("itr_expt_ret", s.res[1], itr_expt_ret);
			check_bit("s_lsu_expt_ready", s.flg[1], s_lsu_expt_ready);
			if (s.res[4])
				check_word("flush_addr", s.faddr, flush_addr);
			if (s.res[3])
			begin
				check_bit("itr_expt_is_intr", s.res[2], itr_expt_is_intr);
				check_cause("itr_expt_cause", s.cause, itr_expt_cause);
				check_word("itr_expt_ret_addr", s.mepc, itr_expt_ret_addr);
				check_word("itr_expt_val", s.mtval, itr_expt_val);
			end
			@(posedge clk);
			#10;
			// flush outstanding, same instruction held and refused
			for (int k = 1; s.res[4] && k <= int'(delay); k++)
			begin
				flush_ack = (k == int'(delay));
				#5;
				check_bit("s_pst_ready", 1'b0, s_pst_ready);
				check_bit("m_pst_valid", 1'b0, m_pst_valid);
				check_bit("flush_req", 1'b0, flush_req);
				@(posedge clk);
				#10;
			end
			clear_inputs();
			csr_sel = CSR_MSTATUS;
			#1;
			check_bit("mstatus.MIE", s.res[0], csr_rdata[`RV_MSTATUS_MIE]);
			if (s.res[3])
			begin
				mcause_exp = '0;
				mcause_exp[7:0] = s.cause; // code field
				mcause_exp[`RV_XLEN-1] = s.res[2]; // interrupt flag
				csr_sel = CSR_MEPC;
				#1;
				check_word("mepc", s.mepc, csr_rdata);
				csr_sel = CSR_MCAUSE;
				#1;
				check_word("mcause", mcause_exp, csr_rdata);
				csr_sel = CSR_MTVAL;
				#1;
				check_word("mtval", s.mtval, csr_rdata);
			end
		end
	endtask

	initial
	begin
		resetn = 1'b0;
		m_pst_ready = 1'b1;
		csr_wen = 1'b0;
		csr_sel = CSR_MSTATUS;
		csr_wdata = '0;
		clear_inputs();
		load_table();
		limit = tbl.size() * 8 + 50;
		repeat (5) @(posedge clk);
		#10;
		resetn = 1'b1;
		for (int i = 0; i < tbl.size(); i++)
			run_step(i);
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* src.f */
+incdir+common
common/rv_commit_pkg.sv
commit/rv_commit.sv
src/rv_trap_csr.sv
src/rv_commit_top.sv
bench/tb_rv_commit.sv

/* Makefile */
TOP = tb_rv_commit

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
